// File: Bender.yml
package:
  name: ddr_bridge

sources:
  - verilog/ddr_bridge_pkg.sv
  - verilog/lane_fifo.sv
  - verilog/axi_master_mux.sv
  - verilog/write_lane_steer.sv
  - verilog/read_lane_select.sv
  - verilog/mem_reset_seq.sv
  - verilog/ddr_bridge_top.sv
  - target: test
    files:
      - bench/ddr_bridge_tb.sv

// File: bench/ddr_bridge_stim.txt
// op(0 write, 1 read, 2 write with data held back, 3 end) master addr data strb expected
// reads ignore data and strb, writes ignore expected
0 0 00000100 11111111 f 00000000
0 0 00000104 22222222 f 00000000
0 0 00000108 33333333 f 00000000
0 0 0000010c 44444444 f 00000000
1 0 00000100 00000000 0 11111111
1 0 0000010c 00000000 0 44444444
1 0 00000108 00000000 0 33333333
0 1 00000204 aabbccdd 3 00000000
1 1 00000204 00000000 0 ffffccdd
1 1 00000208 00000000 0 fffffdf7
0 1 30000120 cafef00d c 00000000
1 0 00000120 00000000 0 cafefedf
2 0 00000300 01234567 f 00000000
2 0 00000314 89abcdef f 00000000
1 0 00000300 00000000 0 01234567
1 0 00000314 00000000 0 89abcdef
2 1 00000408 5a5a5a5a 6 00000000
2 1 0000040c 0f0f0f0f f 00000000
1 1 00000408 00000000 0 ff5a5af7
1 1 0000040c 00000000 0 0f0f0f0f
1 0 00000104 00000000 0 22222222
3 0 00000000 00000000 0 00000000

// File: bench/ddr_bridge_tb.sv
`timescale 1ns/100ps

module ddr_bridge_tb
  import ddr_bridge_pkg::*;
();

  localparam int MAX_REC = 64;

  logic          sys_clk;
  logic          sys_rstn;
  logic          host_sel;
  logic          pll_locked;
  axi_ax_t       m_aw [2];
  logic [1:0]    m_aw_valid;
  logic [1:0]    m_aw_ready;
  axi_w_narrow_t m_w [2];
  logic [1:0]    m_w_valid;
  logic [1:0]    m_w_ready;
  axi_b_t        m_b [2];
  logic [1:0]    m_b_valid;
  logic [1:0]    m_b_ready;
  axi_ax_t       m_ar [2];
  logic [1:0]    m_ar_valid;
  logic [1:0]    m_ar_ready;
  axi_r_narrow_t m_r [2];
  logic [1:0]    m_r_valid;
  logic [1:0]    m_r_ready;
  axi_mem_ax_t   mem_aw;
  logic          mem_aw_valid;
  logic          mem_aw_ready;
  axi_w_wide_t   mem_w;
  logic          mem_w_valid;
  logic          mem_w_ready;
  axi_b_t        mem_b;
  logic          mem_b_valid;
  logic          mem_b_ready;
  axi_mem_ax_t   mem_ar;
  logic          mem_ar_valid;
  logic          mem_ar_ready;
  axi_r_wide_t   mem_r;
  logic          mem_r_valid;
  logic          mem_r_ready;
  logic          mem_rstn;

  logic [31:0]   stim [MAX_REC*6];
  logic [31:0]   lfsr;
  bit            model_on;
  int            err_count;
  int            cycle_count;
  int            cycle_limit;

  // memory model state
  wide_data_t    line_store [mem_addr_t];
  mem_addr_t     exp_aw_q [$];
  mem_addr_t     exp_ar_q [$];
  narrow_data_t  exp_wd_q [$];
  wide_strb_t    exp_ws_q [$];
  mem_addr_t     wr_addr_q [$];
  axi_id_t       wr_id_q [$];
  axi_id_t       b_q [$];
  axi_r_wide_t   r_q [$];

  ddr_bridge_top #(
    .LANE_FIFO_AW (1)
  ) DUT (
    .sys_clk      (sys_clk),
    .sys_rstn     (sys_rstn),
    .host_sel     (host_sel),
    .pll_locked   (pll_locked),
    .m0_aw        (m_aw[0]),
    .m0_aw_valid  (m_aw_valid[0]),
    .m0_aw_ready  (m_aw_ready[0]),
    .m0_w         (m_w[0]),
    .m0_w_valid   (m_w_valid[0]),
    .m0_w_ready   (m_w_ready[0]),
    .m0_b         (m_b[0]),
    .m0_b_valid   (m_b_valid[0]),
    .m0_b_ready   (m_b_ready[0]),
    .m0_ar        (m_ar[0]),
    .m0_ar_valid  (m_ar_valid[0]),
    .m0_ar_ready  (m_ar_ready[0]),
    .m0_r         (m_r[0]),
    .m0_r_valid   (m_r_valid[0]),
    .m0_r_ready   (m_r_ready[0]),
    .m1_aw        (m_aw[1]),
    .m1_aw_valid  (m_aw_valid[1]),
    .m1_aw_ready  (m_aw_ready[1]),
    .m1_w         (m_w[1]),
    .m1_w_valid   (m_w_valid[1]),
    .m1_w_ready   (m_w_ready[1]),
    .m1_b         (m_b[1]),
    .m1_b_valid   (m_b_valid[1]),
    .m1_b_ready   (m_b_ready[1]),
    .m1_ar        (m_ar[1]),
    .m1_ar_valid  (m_ar_valid[1]),
    .m1_ar_ready  (m_ar_ready[1]),
    .m1_r         (m_r[1]),
    .m1_r_valid   (m_r_valid[1]),
    .m1_r_ready   (m_r_ready[1]),
    .mem_aw       (mem_aw),
    .mem_aw_valid (mem_aw_valid),
    .mem_aw_ready (mem_aw_ready),
    .mem_w        (mem_w),
    .mem_w_valid  (mem_w_valid),
    .mem_w_ready  (mem_w_ready),
    .mem_b        (mem_b),
    .mem_b_valid  (mem_b_valid),
    .mem_b_ready  (mem_b_ready),
    .mem_ar       (mem_ar),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_ready (mem_ar_ready),
    .mem_r        (mem_r),
    .mem_r_valid  (mem_r_valid),
    .mem_r_ready  (mem_r_ready),
    .mem_rstn     (mem_rstn)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // unwritten word reads back as the inverse of its byte address
  function automatic wide_data_t line_fill(mem_addr_t la);
    wide_data_t v;
    for (int i = 0; i < 4; i++)
      v[i*32 +: 32] = ~({4'h0, la} + 32'(i * 4));
    return v;
  endfunction

  task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] act);
    $display("FAILED at %0.1f ns: %s expected %0h got %0h", $realtime, name, exp, act);
    err_count++;
  endtask

  task automatic report_problem(string what);
    $display("ERROR at %0.1f ns: %s", $realtime, what);
    err_count++;
  endtask

  // --------------------------------------------------
  // wide memory model
  // --------------------------------------------------
  always @(negedge sys_clk) begin
    if (model_on) begin
      lfsr = lfsr_step(lfsr);
      mem_aw_ready = lfsr[0];            // one step per ready bit
      lfsr = lfsr_step(lfsr);
      mem_w_ready = lfsr[0];
      lfsr = lfsr_step(lfsr);
      mem_ar_ready = lfsr[0];
    end
    mem_b_valid = (b_q.size() != 0);
    mem_b = '0;
    if (b_q.size() != 0)
      mem_b.id = b_q[0];
    mem_r_valid = (r_q.size() != 0);
    mem_r = '0;
    if (r_q.size() != 0)
      mem_r = r_q[0];
  end

  always @(posedge sys_clk) begin
    mem_addr_t   la;
    wide_data_t  ln;
    axi_r_wide_t rd;
    narrow_data_t d;
    wide_strb_t  s;
    if (model_on) begin
      if (mem_aw_valid && mem_aw_ready) begin
        if (exp_aw_q.size() == 0) begin
          report_problem("memory write address seen with no write issued");
        end else begin
          la = exp_aw_q.pop_front();
          if (mem_aw.addr !== la)
            report_mismatch("mem_aw.addr", la, mem_aw.addr);
        end
        wr_addr_q.push_back(mem_aw.addr);
        wr_id_q.push_back(mem_aw.id);
      end
      if (mem_w_valid && mem_w_ready) begin
        if (wr_addr_q.size() == 0 || exp_wd_q.size() == 0) begin
          report_problem("memory write data seen before its address");
        end else begin
          d = exp_wd_q.pop_front();
          s = exp_ws_q.pop_front();
          if (mem_w.data !== {4{d}})
            report_mismatch("mem_w.data", {4{d}}, mem_w.data);
          if (mem_w.strb !== s)
            report_mismatch("mem_w.strb", s, mem_w.strb);
          if (mem_w.last !== 1'b1)
            report_mismatch("mem_w.last", 1, mem_w.last);
          la = wr_addr_q.pop_front();
          ln = line_store.exists(la) ? line_store[la] : line_fill(la);
          for (int i = 0; i < 16; i++)
            if (mem_w.strb[i])
              ln[i*8 +: 8] = mem_w.data[i*8 +: 8];
          line_store[la] = ln;
          b_q.push_back(wr_id_q.pop_front());
        end
      end
      if (mem_b_valid && mem_b_ready)
        void'(b_q.pop_front());
      if (mem_ar_valid && mem_ar_ready) begin
        if (exp_ar_q.size() == 0) begin
          report_problem("memory read address seen with no read issued");
        end else begin
          la = exp_ar_q.pop_front();
          if (mem_ar.addr !== la)
            report_mismatch("mem_ar.addr", la, mem_ar.addr);
        end
        rd.id   = mem_ar.id;
        rd.data = line_store.exists(mem_ar.addr) ? line_store[mem_ar.addr]
                                                 : line_fill(mem_ar.addr);
        rd.resp = 2'b00;
        rd.last = 1'b1;
        r_q.push_back(rd);
      end
      if (mem_r_valid && mem_r_ready)
        void'(r_q.pop_front());
      // narrow readies follow the wide ones
      if (!mem_aw_ready && m_aw_ready[host_sel])
        report_problem("aw_ready high while memory aw_ready is low");
      if (!mem_w_ready && m_w_ready[host_sel])
        report_problem("w_ready high while memory w_ready is low");
      if (!mem_ar_ready && m_ar_ready[host_sel])
        report_problem("ar_ready high while memory ar_ready is low");
      // the idle master sees nothing
      if ({m_aw_ready[!host_sel], m_w_ready[!host_sel], m_ar_ready[!host_sel],
           m_b_valid[!host_sel], m_r_valid[!host_sel]} !== 5'b0)
        report_problem("unselected master sees a ready or valid high");
      if (m_b[!host_sel] !== '0 || m_r[!host_sel] !== '0)
        report_problem("unselected master sees a nonzero response payload");
      // lock held for the rest of the run, counter must stay saturated
      if (mem_rstn !== 1'b1)
        report_mismatch("mem_rstn while locked", 1, mem_rstn);
    end
  end

  // --------------------------------------------------
  // master drivers
  // --------------------------------------------------
  task automatic select_master(int m);
    @(negedge sys_clk);
    host_sel = m[0];
  endtask

  task automatic send_aw(int m, addr_t a, narrow_data_t d, narrow_strb_t s, axi_id_t id);
    @(negedge sys_clk);
    m_aw[m] = '{id: id, addr: a, len: 8'd0, size: 3'd2, burst: 2'b01,
                lock: 1'b0, cache: 4'd0, prot: 3'd0};
    m_w[m] = '{data: d, strb: s, last: 1'b1};   // strobe rides with the address
    exp_aw_q.push_back({a[27:4], 4'h0});
    exp_wd_q.push_back(d);
    exp_ws_q.push_back(wide_strb_t'(s) << (4 * a[3:2]));
    m_aw_valid[m] = 1'b1;
    do @(posedge sys_clk); while (!m_aw_ready[m]);
    @(negedge sys_clk);
    m_aw_valid[m] = 1'b0;
  endtask

  task automatic send_w(int m, narrow_data_t d, narrow_strb_t s);
    @(negedge sys_clk);
    m_w[m] = '{data: d, strb: s, last: 1'b1};
    m_w_valid[m] = 1'b1;
    do @(posedge sys_clk); while (!m_w_ready[m]);
    @(negedge sys_clk);
    m_w_valid[m] = 1'b0;
  endtask

  task automatic take_b(int m, axi_id_t id);
    @(negedge sys_clk);
    m_b_ready[m] = 1'b1;
    do @(posedge sys_clk); while (!m_b_valid[m]);
    if (m_b[m].id !== id)
      report_mismatch("b.id", id, m_b[m].id);
    if (m_b[m].resp !== 2'b00)
      report_mismatch("b.resp", 0, m_b[m].resp);
    @(negedge sys_clk);
    m_b_ready[m] = 1'b0;
  endtask

  task automatic send_ar(int m, addr_t a, axi_id_t id);
    @(negedge sys_clk);
    m_ar[m] = '{id: id, addr: a, len: 8'd0, size: 3'd2, burst: 2'b01,
                lock: 1'b0, cache: 4'd0, prot: 3'd0};
    exp_ar_q.push_back({a[27:4], 4'h0});
    m_ar_valid[m] = 1'b1;
    do @(posedge sys_clk); while (!m_ar_ready[m]);
    @(negedge sys_clk);
    m_ar_valid[m] = 1'b0;
  endtask

  task automatic take_r(int m, axi_id_t id, narrow_data_t exp);
    @(negedge sys_clk);
    m_r_ready[m] = 1'b1;
    do @(posedge sys_clk); while (!m_r_valid[m]);
    if (m_r[m].data !== exp)
      report_mismatch("r.data", exp, m_r[m].data);
    if (m_r[m].id !== id)
      report_mismatch("r.id", id, m_r[m].id);
    if (m_r[m].resp !== 2'b00 || m_r[m].last !== 1'b1)
      report_problem("read response not OKAY or not marked last");
    @(negedge sys_clk);
    m_r_ready[m] = 1'b0;
  endtask

  // --------------------------------------------------
  // reset sequence
  // --------------------------------------------------
  task automatic check_idle_outputs();
    if ({m_aw_ready, m_w_ready, m_ar_ready, m_b_valid, m_r_valid} !== 10'b0)
      report_problem("a master ready or valid is high after reset");
    if ({mem_aw_valid, mem_w_valid, mem_ar_valid, mem_b_ready, mem_r_ready} !== 5'b0)
      report_problem("a memory valid or ready is high after reset");
    if (mem_rstn !== 1'b0)
      report_mismatch("mem_rstn", 0, mem_rstn);
  endtask

  task automatic lock_and_measure();
    int edges;
    @(negedge sys_clk);
    pll_locked = 1'b1;
    edges = 0;
    do begin
      @(posedge sys_clk);
      edges++;
      @(negedge sys_clk);
    end while (mem_rstn !== 1'b1 && edges < 200);
    if (edges != 129)
      report_mismatch("mem_rstn release edge", 129, edges);
  endtask

  task automatic drop_lock();
    pll_locked = 1'b0;
    @(posedge sys_clk);
    @(negedge sys_clk);
    if (mem_rstn !== 1'b1)
      report_mismatch("mem_rstn on the edge that samples lock low", 1, mem_rstn);
    @(posedge sys_clk);
    @(negedge sys_clk);
    if (mem_rstn !== 1'b0)
      report_mismatch("mem_rstn one edge later", 0, mem_rstn);
  endtask

  // cycle guard
  always @(posedge sys_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("ERROR: run passed %0d cycles, a handshake never completed", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int       n_rec;
    int       op;
    int       m;
    int       errs_before;
    int       n_pass;
    int       n_fail;
    addr_t    a;
    axi_id_t  id;
    addr_t    pend_a [$];
    narrow_data_t pend_d [$];
    narrow_strb_t pend_s [$];
    axi_id_t  pend_id [$];
    sys_rstn   = 1'b0;
    host_sel   = 1'b0;
    pll_locked = 1'b0;
    m_aw_valid = '0;
    m_w_valid  = '0;
    m_b_ready  = '0;
    m_ar_valid = '0;
    m_r_ready  = '0;
    for (int i = 0; i < 2; i++) begin
      m_aw[i] = '0;
      m_w[i]  = '0;
      m_ar[i] = '0;
    end
    mem_aw_ready = 1'b0;
    mem_w_ready  = 1'b0;
    mem_ar_ready = 1'b0;
    mem_b        = '0;
    mem_b_valid  = 1'b0;
    mem_r        = '0;
    mem_r_valid  = 1'b0;
    model_on     = 1'b0;
    lfsr         = 32'hc6bc;
    err_count    = 0;
    cycle_count  = 0;
    n_pass       = 0;
    n_fail       = 0;
    $readmemh("bench/ddr_bridge_stim.txt", stim);
    n_rec = 0;
    while (n_rec < MAX_REC && stim[n_rec*6] !== 32'h3)
      n_rec++;
    cycle_limit = 64 * n_rec + 400;

    repeat (8) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rstn = 1'b1;
    @(negedge sys_clk);
    errs_before = err_count;
    check_idle_outputs();
    lock_and_measure();
    drop_lock();
    lock_and_measure();
    if (err_count == errs_before) n_pass++;
    else n_fail++;
    $display("test reset sequence: %s", (err_count == errs_before) ? "pass" : "fail");

    model_on = 1'b1;
    for (int rec = 0; rec < n_rec; rec++) begin
      errs_before = err_count;
      op = stim[rec*6];
      m  = stim[rec*6+1];
      a  = stim[rec*6+2];
      id = axi_id_t'(rec);
      if (op == 0) begin
        select_master(m);
        send_aw(m, a, stim[rec*6+3], stim[rec*6+4], id);
        send_w(m, stim[rec*6+3], stim[rec*6+4]);
        take_b(m, id);
      end else if (op == 1) begin
        select_master(m);
        send_ar(m, a, id);
        take_r(m, id, stim[rec*6+5]);
      end else begin
        if (pend_a.size() == 0)
          select_master(m);
        send_aw(m, a, stim[rec*6+3], stim[rec*6+4], id);
        pend_a.push_back(a);
        pend_d.push_back(stim[rec*6+3]);
        pend_s.push_back(stim[rec*6+4]);
        pend_id.push_back(id);
        if (pend_a.size() == 2) begin
          // tag FIFO full so no further address may go in
          repeat (8) begin
            @(posedge sys_clk);
            if (m_aw_ready[m] !== 1'b0)
              report_problem("aw_ready high with two writes waiting for data");
          end
          for (int i = 0; i < 2; i++)
            send_w(m, pend_d[i], pend_s[i]);
          for (int i = 0; i < 2; i++)
            take_b(m, pend_id[i]);
          pend_a.delete();
          pend_d.delete();
          pend_s.delete();
          pend_id.delete();
        end
      end
      if (err_count == errs_before) n_pass++;
      else n_fail++;
      $display("test %0d op %0d master %0d addr %h: %s", rec, op, m, a,
               (err_count == errs_before) ? "pass" : "fail");
    end

    repeat (4) @(posedge sys_clk);
    $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, err_count);
    if (err_count == 0 && n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
verilog/ddr_bridge_pkg.sv
verilog/lane_fifo.sv
verilog/axi_master_mux.sv
verilog/write_lane_steer.sv
verilog/read_lane_select.sv
verilog/mem_reset_seq.sv
verilog/ddr_bridge_top.sv
bench/ddr_bridge_tb.sv

// File: verilog/axi_master_mux.sv
`timescale 1ns/100ps

module axi_master_mux
  import ddr_bridge_pkg::*;
(
  input  logic          host_sel,      // 0 dma side, 1 debug side
  // master 0
  input  axi_ax_t       m0_aw,
  input  logic          m0_aw_valid,
  output logic          m0_aw_ready,
  input  axi_w_narrow_t m0_w,
  input  logic          m0_w_valid,
  output logic          m0_w_ready,
  output axi_b_t        m0_b,
  output logic          m0_b_valid,
  input  logic          m0_b_ready,
  input  axi_ax_t       m0_ar,
  input  logic          m0_ar_valid,
  output logic          m0_ar_ready,
  output axi_r_narrow_t m0_r,
  output logic          m0_r_valid,
  input  logic          m0_r_ready,
  // master 1
  input  axi_ax_t       m1_aw,
  input  logic          m1_aw_valid,
  output logic          m1_aw_ready,
  input  axi_w_narrow_t m1_w,
  input  logic          m1_w_valid,
  output logic          m1_w_ready,
  output axi_b_t        m1_b,
  output logic          m1_b_valid,
  input  logic          m1_b_ready,
  input  axi_ax_t       m1_ar,
  input  logic          m1_ar_valid,
  output logic          m1_ar_ready,
  output axi_r_narrow_t m1_r,
  output logic          m1_r_valid,
  input  logic          m1_r_ready,
  // selected master
  output axi_ax_t       aw,
  output logic          aw_valid,
  input  logic          aw_ready,
  output axi_w_narrow_t w,
  output logic          w_valid,
  input  logic          w_ready,
  input  axi_b_t        b,
  input  logic          b_valid,
  output logic          b_ready,
  output axi_ax_t       ar,
  output logic          ar_valid,
  input  logic          ar_ready,
  input  axi_r_narrow_t r,
  input  logic          r_valid,
  output logic          r_ready
);

  // --------------------------------------------------
  // requests toward the bridge
  // --------------------------------------------------
  assign aw       = host_sel ? m1_aw       : m0_aw;
  assign aw_valid = host_sel ? m1_aw_valid : m0_aw_valid;
  assign w        = host_sel ? m1_w        : m0_w;
  assign w_valid  = host_sel ? m1_w_valid  : m0_w_valid;
  assign ar       = host_sel ? m1_ar       : m0_ar;
  assign ar_valid = host_sel ? m1_ar_valid : m0_ar_valid;
  assign b_ready  = host_sel ? m1_b_ready  : m0_b_ready;
  assign r_ready  = host_sel ? m1_r_ready  : m0_r_ready;

  // --------------------------------------------------
  // readies and responses back to the masters
  // --------------------------------------------------
  always_comb begin
    m0_aw_ready = 1'b0;           // idle side sees nothing
    m0_w_ready  = 1'b0;
    m0_ar_ready = 1'b0;
    m0_b        = '0;
    m0_b_valid  = 1'b0;
    m0_r        = '0;
    m0_r_valid  = 1'b0;
    m1_aw_ready = 1'b0;
    m1_w_ready  = 1'b0;
    m1_ar_ready = 1'b0;
    m1_b        = '0;
    m1_b_valid  = 1'b0;
    m1_r        = '0;
    m1_r_valid  = 1'b0;
    if (host_sel) begin
      m1_aw_ready = aw_ready;
      m1_w_ready  = w_ready;
      m1_ar_ready = ar_ready;
      m1_b        = b;
      m1_b_valid  = b_valid;
      m1_r        = r;
      m1_r_valid  = r_valid;
    end else begin
      m0_aw_ready = aw_ready;
      m0_w_ready  = w_ready;
      m0_ar_ready = ar_ready;
      m0_b        = b;
      m0_b_valid  = b_valid;
      m0_r        = r;
      m0_r_valid  = r_valid;
    end
  end

endmodule

// File: verilog/ddr_bridge_pkg.sv
package ddr_bridge_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int AXI_ID_W     = 4;
  localparam int ADDR_W       = 32;
  localparam int MEM_ADDR_W   = 28;                      // controller byte address
  localparam int NARROW_DW    = 32;
  localparam int NARROW_SW    = NARROW_DW / 8;
  localparam int NUM_LANES    = 4;                       // narrow words per line
  localparam int WIDE_DW      = NARROW_DW * NUM_LANES;
  localparam int WORD_OFS_W   = $clog2(NARROW_SW);       // byte offset within a word
  localparam int LINE_OFS_W   = $clog2(WIDE_DW / 8);     // byte offset within a line
  localparam int LOCK_CNT_W   = 8;                       // top bit releases mem reset

  typedef logic [AXI_ID_W-1:0]           axi_id_t;
  typedef logic [ADDR_W-1:0]             addr_t;
  typedef logic [MEM_ADDR_W-1:0]         mem_addr_t;
  typedef logic [NARROW_DW-1:0]          narrow_data_t;
  typedef logic [NARROW_SW-1:0]          narrow_strb_t;
  typedef logic [WIDE_DW-1:0]            wide_data_t;
  typedef logic [WIDE_DW/8-1:0]          wide_strb_t;
  typedef logic [$clog2(NUM_LANES)-1:0]  lane_t;
  typedef logic [1:0]                    resp_t;

  // --------------------------------------------------
  // channel payloads, valid/ready kept outside
  // --------------------------------------------------
  typedef struct packed {
    axi_id_t     id;
    addr_t       addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
    logic        lock;
    logic [3:0]  cache;
    logic [2:0]  prot;
  } axi_ax_t;

  typedef struct packed {
    axi_id_t     id;
    mem_addr_t   addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
    logic        lock;
    logic [3:0]  cache;
    logic [2:0]  prot;
  } axi_mem_ax_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic         last;
  } axi_w_narrow_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } axi_w_wide_t;

  typedef struct packed {
    axi_id_t id;
    resp_t   resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t      id;
    narrow_data_t data;
    resp_t        resp;
    logic         last;
  } axi_r_narrow_t;

  typedef struct packed {
    axi_id_t    id;
    wide_data_t data;
    resp_t      resp;
    logic       last;
  } axi_r_wide_t;

  // narrow address request onto the line-aligned memory request
  function automatic axi_mem_ax_t align_ax(axi_ax_t ax);
    axi_mem_ax_t m;
    m.id    = ax.id;
    m.addr  = {ax.addr[MEM_ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
    m.len   = ax.len;
    m.size  = ax.size;
    m.burst = ax.burst;
    m.lock  = ax.lock;
    m.cache = ax.cache;
    m.prot  = ax.prot;
    return m;
  endfunction

  // word lane of a narrow address within its line
  function automatic lane_t lane_of(addr_t addr);
    return addr[LINE_OFS_W-1:WORD_OFS_W];
  endfunction

endpackage

// File: verilog/ddr_bridge_top.sv
`timescale 1ns/100ps

module ddr_bridge_top
  import ddr_bridge_pkg::*;
#(
  parameter int LANE_FIFO_AW = 1     // log2 of lane FIFO depth
) (
  input  logic          sys_clk,
  input  logic          sys_rstn,
  input  logic          host_sel,
  input  logic          pll_locked,
  // master 0, dma side
  input  axi_ax_t       m0_aw,
  input  logic          m0_aw_valid,
  output logic          m0_aw_ready,
  input  axi_w_narrow_t m0_w,
  input  logic          m0_w_valid,
  output logic          m0_w_ready,
  output axi_b_t        m0_b,
  output logic          m0_b_valid,
  input  logic          m0_b_ready,
  input  axi_ax_t       m0_ar,
  input  logic          m0_ar_valid,
  output logic          m0_ar_ready,
  output axi_r_narrow_t m0_r,
  output logic          m0_r_valid,
  input  logic          m0_r_ready,
  // master 1, debug side
  input  axi_ax_t       m1_aw,
  input  logic          m1_aw_valid,
  output logic          m1_aw_ready,
  input  axi_w_narrow_t m1_w,
  input  logic          m1_w_valid,
  output logic          m1_w_ready,
  output axi_b_t        m1_b,
  output logic          m1_b_valid,
  input  logic          m1_b_ready,
  input  axi_ax_t       m1_ar,
  input  logic          m1_ar_valid,
  output logic          m1_ar_ready,
  output axi_r_narrow_t m1_r,
  output logic          m1_r_valid,
  input  logic          m1_r_ready,
  // memory controller port
  output axi_mem_ax_t   mem_aw,
  output logic          mem_aw_valid,
  input  logic          mem_aw_ready,
  output axi_w_wide_t   mem_w,
  output logic          mem_w_valid,
  input  logic          mem_w_ready,
  input  axi_b_t        mem_b,
  input  logic          mem_b_valid,
  output logic          mem_b_ready,
  output axi_mem_ax_t   mem_ar,
  output logic          mem_ar_valid,
  input  logic          mem_ar_ready,
  input  axi_r_wide_t   mem_r,
  input  logic          mem_r_valid,
  output logic          mem_r_ready,
  output logic          mem_rstn
);

  // --------------------------------------------------
  // selected narrow master
  // --------------------------------------------------
  axi_ax_t       aw;
  logic          aw_valid;
  logic          aw_ready;
  axi_w_narrow_t w;
  logic          w_valid;
  logic          w_ready;
  axi_b_t        b;
  logic          b_valid;
  logic          b_ready;
  axi_ax_t       ar;
  logic          ar_valid;
  logic          ar_ready;
  axi_r_narrow_t r;
  logic          r_valid;
  logic          r_ready;

  // port names line up with the nets above
  axi_master_mux u_axi_master_mux (.*);

  write_lane_steer #(
    .LANE_FIFO_AW (LANE_FIFO_AW)
  ) u_write_lane_steer (.*);

  read_lane_select #(
    .LANE_FIFO_AW (LANE_FIFO_AW)
  ) u_read_lane_select (.*);

  mem_reset_seq u_mem_reset_seq (.*);

endmodule

// File: verilog/lane_fifo.sv
`timescale 1ns/100ps

module lane_fifo #(
  parameter int DATA_W = 6,
  parameter int ADDR_W = 1
) (
  input  logic              sys_clk,
  input  logic              sys_rstn,
  input  logic              push,
  input  logic [DATA_W-1:0] push_data,
  input  logic              pop,
  output logic [DATA_W-1:0] pop_data,
  output logic              full,
  output logic              empty
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] entry [DEPTH];
  logic [ADDR_W:0]   wr_ptr;     // extra bit tells full from empty
  logic [ADDR_W:0]   rd_ptr;

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (push)
      entry[wr_ptr[ADDR_W-1:0]] <= push_data;
  end

  assign pop_data = entry[rd_ptr[ADDR_W-1:0]];  // head always visible
  assign empty    = (wr_ptr == rd_ptr);
  assign full     = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

endmodule

// File: verilog/mem_reset_seq.sv
`timescale 1ns/100ps

module mem_reset_seq
  import ddr_bridge_pkg::*;
(
  input  logic sys_clk,
  input  logic sys_rstn,
  input  logic pll_locked,
  output logic mem_rstn
);

  logic [LOCK_CNT_W-1:0] lock_cnt;   // cycles of stable lock

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn)
      lock_cnt <= '0;
    else if (!pll_locked)
      lock_cnt <= '0;              // lost lock, start over
    else if (lock_cnt != '1)
      lock_cnt <= lock_cnt + 1'b1; // hold at max
  end

  // release once 128 locked cycles have passed
  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn)
      mem_rstn <= 1'b0;
    else
      mem_rstn <= lock_cnt[LOCK_CNT_W-1];
  end

endmodule

// File: verilog/read_lane_select.sv
`timescale 1ns/100ps

module read_lane_select
  import ddr_bridge_pkg::*;
#(
  parameter int LANE_FIFO_AW = 1
) (
  input  logic          sys_clk,
  input  logic          sys_rstn,
  // narrow side
  input  axi_ax_t       ar,
  input  logic          ar_valid,
  output logic          ar_ready,
  output axi_r_narrow_t r,
  output logic          r_valid,
  input  logic          r_ready,
  // memory side
  output axi_mem_ax_t   mem_ar,
  output logic          mem_ar_valid,
  input  logic          mem_ar_ready,
  input  axi_r_wide_t   mem_r,
  input  logic          mem_r_valid,
  output logic          mem_r_ready
);

  lane_t head_lane;
  logic  lane_full;
  logic  lane_empty;

  // AR, line aligned, lane kept for the answer
  assign ar_ready     = mem_ar_ready && !lane_full;
  assign mem_ar_valid = ar_valid && ar_ready;
  assign mem_ar       = align_ax(ar);

  lane_fifo #(
    .DATA_W ($bits(lane_t)),
    .ADDR_W (LANE_FIFO_AW)
  ) u_lane_fifo (
    .sys_clk   (sys_clk),
    .sys_rstn  (sys_rstn),
    .push      (ar_valid && ar_ready),
    .push_data (lane_of(ar.addr)),
    .pop       (r_valid && r_ready),
    .pop_data  (head_lane),
    .full      (lane_full),
    .empty     (lane_empty)
  );

  // --------------------------------------------------
  // R, pick the recorded word out of the line
  // --------------------------------------------------
  assign r_valid     = mem_r_valid && !lane_empty;  // no data without an open read
  assign mem_r_ready = r_ready && !lane_empty;

  assign r.id   = mem_r.id;
  assign r.data = mem_r.data[head_lane*NARROW_DW +: NARROW_DW];
  assign r.resp = mem_r.resp;
  assign r.last = mem_r.last;

endmodule

// File: verilog/write_lane_steer.sv
`timescale 1ns/100ps

module write_lane_steer
  import ddr_bridge_pkg::*;
#(
  parameter int LANE_FIFO_AW = 1
) (
  input  logic          sys_clk,
  input  logic          sys_rstn,
  // narrow side
  input  axi_ax_t       aw,
  input  logic          aw_valid,
  output logic          aw_ready,
  input  axi_w_narrow_t w,
  input  logic          w_valid,
  output logic          w_ready,
  output axi_b_t        b,
  output logic          b_valid,
  input  logic          b_ready,
  // memory side
  output axi_mem_ax_t   mem_aw,
  output logic          mem_aw_valid,
  input  logic          mem_aw_ready,
  output axi_w_wide_t   mem_w,
  output logic          mem_w_valid,
  input  logic          mem_w_ready,
  input  axi_b_t        mem_b,
  input  logic          mem_b_valid,
  output logic          mem_b_ready
);

  // one tag per accepted AW
  typedef struct packed {
    narrow_strb_t strb;
    lane_t        lane;
  } wr_tag_t;

  wr_tag_t push_tag;
  wr_tag_t head_tag;
  logic    tag_full;
  logic    tag_empty;

  // --------------------------------------------------
  // AW
  // --------------------------------------------------
  assign aw_ready     = mem_aw_ready && !tag_full;
  assign mem_aw_valid = aw_valid && aw_ready;
  assign mem_aw       = align_ax(aw);

  assign push_tag.strb = w.strb;     // strobe sampled with the address
  assign push_tag.lane = lane_of(aw.addr);

  lane_fifo #(
    .DATA_W ($bits(wr_tag_t)),
    .ADDR_W (LANE_FIFO_AW)
  ) u_tag_fifo (
    .sys_clk   (sys_clk),
    .sys_rstn  (sys_rstn),
    .push      (aw_valid && aw_ready),
    .push_data (push_tag),
    .pop       (mem_w_valid && mem_w_ready),
    .pop_data  (head_tag),
    .full      (tag_full),
    .empty     (tag_empty)
  );

  // --------------------------------------------------
  // W, data on every lane, strobe on one
  // --------------------------------------------------
  assign w_ready     = mem_w_ready && !tag_empty;
  assign mem_w_valid = w_valid && w_ready;

  always_comb begin
    mem_w.data = {NUM_LANES{w.data}};
    mem_w.last = w.last;
    for (int i = 0; i < NUM_LANES; i++) begin
      mem_w.strb[i*NARROW_SW +: NARROW_SW] = (head_tag.lane == lane_t'(i)) ? head_tag.strb : '0;
    end
  end

  // B untouched
  assign b           = mem_b;
  assign b_valid     = mem_b_valid;
  assign mem_b_ready = b_ready;

endmodule
